// ==== address_decode_unit.sv ====
module address_decode_unit (
    input  vec_proc_pkg::instr_t     instr,
    output vec_proc_pkg::reg_addrs_t addrs
);
    import vec_proc_pkg::*;

    reg_form_t rf;
    imm_form_t imf;

    assign rf  = instr.reg_form;
    assign imf = instr.imm_form;

    always_comb begin
        if (!rf.mode) begin
            addrs.s1  = rf.src1;
            addrs.s2  = rf.src2;
            addrs.swb = rf.dst;
            addrs.v1  = rf.src1[3:0];
            addrs.v2  = rf.src2[3:0];
            addrs.vwb = rf.dst[3:0];

            if (rf.cls[2:1] == 2'b00) begin
                // Vector-vector, bit 28 suppresses the vector writeback
                addrs.s1  = '0;
                addrs.s2  = '0;
                addrs.swb = '0;
                if (rf.cls[0]) begin
                    addrs.vwb = '0;
                end
            end else if (rf.cls == 3'b010) begin
                // Vector-scalar
                addrs.s1  = '0;
                addrs.v2  = '0;
                addrs.swb = '0;
            end else if (rf.cls == 3'b011) begin
                addrs.v1  = '0;
                addrs.v2  = '0;
                addrs.vwb = '0;
            end else begin
                // Scalar ops
                addrs.v1  = '0;
                addrs.v2  = '0;
                addrs.vwb = '0;
                if (rf.cls[0]) begin
                    addrs.swb = '0;
                end
            end
        end else begin
            addrs.s1  = imf.src;
            addrs.s2  = '0;
            addrs.swb = imf.dst;
            addrs.v1  = imf.src[3:0];
            addrs.v2  = '0;
            addrs.vwb = imf.dst[3:0];

            if (!imf.wr_dis) begin
                case (imf.cls)
                    2'b00, 2'b10: begin
                        addrs.v1  = '0;
                        addrs.vwb = '0;
                    end
                    2'b01: begin
                        case (imf.sub)
                            2'b00, 2'b01: begin
                                addrs.s1  = '0;
                                addrs.vwb = '0;
                            end
                            2'b10: begin
                                addrs.v1  = '0;
                                addrs.vwb = '0;
                            end
                            default: begin
                                addrs.v1  = imf.dst[3:0];
                                addrs.swb = '0;
                            end
                        endcase
                    end
                    default: begin
                        // Load, sub bit 1 picks the vector target
                        addrs.v1 = '0;
                        if (imf.sub[1]) begin
                            addrs.swb = '0;
                        end else begin
                            addrs.vwb = '0;
                        end
                    end
                endcase
            end else begin
                addrs.s1  = '0;
                addrs.swb = '0;
                addrs.v1  = '0;
                addrs.vwb = '0;
                // Store, dst field names the data register
                if (imf.cls == 2'b11) begin
                    addrs.s1 = imf.src;
                    if (imf.sub == 2'b11) begin
                        addrs.v1 = imf.dst[3:0];
                    end else begin
                        addrs.s2 = imf.dst;
                    end
                end
            end
        end
    end

endmodule

// ==== decode_stage.sv ====
module decode_stage #(
    parameter int LANES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  vec_proc_pkg::instr_t     instr,
    input  logic                     s_wr_en,
    input  vec_proc_pkg::sreg_addr_t s_wr_addr,
    input  logic [31:0]              s_wr_data,
    input  logic                     v_wr_en,
    input  vec_proc_pkg::vreg_addr_t v_wr_addr,
    input  logic [LANES*32-1:0]      v_wr_data,
    output vec_proc_pkg::de_scalar_t de_out,
    output logic [LANES*32-1:0]      de_v1_data,
    output logic [LANES*32-1:0]      de_v2_data
);
    import vec_proc_pkg::*;

    reg_addrs_t          addrs;
    logic [31:0]         s1_rd;
    logic [31:0]         s2_rd;
    logic [LANES*32-1:0] v1_rd;
    logic [LANES*32-1:0] v2_rd;

    address_decode_unit u_decode (
        .instr (instr),
        .addrs (addrs)
    );

    scalar_reg_file u_sregs (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (addrs.s1),
        .rd_addr_b (addrs.s2),
        .rd_data_a (s1_rd),
        .rd_data_b (s2_rd),
        .wr_en     (s_wr_en),
        .wr_addr   (s_wr_addr),
        .wr_data   (s_wr_data)
    );

    vector_reg_file #(
        .LANES (LANES)
    ) u_vregs (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (addrs.v1),
        .rd_addr_b (addrs.v2),
        .rd_data_a (v1_rd),
        .rd_data_b (v2_rd),
        .wr_en     (v_wr_en),
        .wr_addr   (v_wr_addr),
        .wr_data   (v_wr_data)
    );

    // Decode-to-execute register, payload held between valid words
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_out     <= '0;
            de_v1_data <= '0;
            de_v2_data <= '0;
        end else begin
            de_out.valid <= instr_valid;
            if (instr_valid) begin
                de_out.instr   <= instr;
                de_out.addrs   <= addrs;
                de_out.s1_data <= s1_rd;
                de_out.s2_data <= s2_rd;
                de_v1_data     <= v1_rd;
                de_v2_data     <= v2_rd;
            end
        end
    end

endmodule

// ==== decode_stage_props.sv ====
module decode_stage_props #(
    parameter int LANES = 4
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     instr_valid,
    input vec_proc_pkg::de_scalar_t de_out,
    input logic [LANES*32-1:0]      de_v1_data,
    input logic [LANES*32-1:0]      de_v2_data
);
    timeunit 1ns;
    timeprecision 1ps;

    reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !de_out.valid)
        else $error("de_out.valid high in reset or on the first edge after it");

    // One output valid per sampled instr_valid
    valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> de_out.valid == $past(instr_valid))
        else $error("de_out.valid does not follow instr_valid of the previous edge");

    // Register 0 reads zero in both files
    zero_scalar: assert property (@(posedge clk) disable iff (!rst_n)
        (de_out.addrs.s1 != '0 || de_out.s1_data == '0) &&
        (de_out.addrs.s2 != '0 || de_out.s2_data == '0))
        else $error("scalar operand from register 0 is not zero");

    zero_vector: assert property (@(posedge clk) disable iff (!rst_n)
        (de_out.addrs.v1 != '0 || de_v1_data == '0) &&
        (de_out.addrs.v2 != '0 || de_v2_data == '0))
        else $error("vector operand from register 0 is not zero");

endmodule

bind decode_stage decode_stage_props #(
    .LANES (LANES)
) u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .de_out      (de_out),
    .de_v1_data  (de_v1_data),
    .de_v2_data  (de_v2_data)
);

// ==== decode_stim.txt ====
# op waddr wdata instr | expected s1 s2 swb v1 v2 vwb | s1_data s2_data v1_lane v2_lane
# all fields hex; W/V write a register, I issues, B writes both files and issues
I 00 00000000 40232800 03 05 01 0 0 0 00000000 00000000 00000000 00000000
W 03 11110003 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
W 05 11110005 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
W 06 11110006 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
W 12 11110012 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
W 15 11110015 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
W 00 DEADBEEF 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
V 02 22220002 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
V 03 22220003 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
V 05 22220005 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
V 06 22220006 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
V 00 CAFEF00D 00000000 00 00 00 0 0 0 00000000 00000000 00000000 00000000
I 00 00000000 00C32800 00 00 00 3 5 6 00000000 00000000 22220003 22220005
I 00 00000000 10F2A800 00 00 00 2 5 0 00000000 00000000 22220002 22220005
I 00 00000000 20A6A800 00 15 00 6 0 5 00000000 11110015 22220006 00000000
I 00 00000000 32433000 03 06 12 0 0 0 11110003 11110006 00000000 00000000
I 00 00000000 5132A800 12 15 00 0 0 0 11110012 11110015 00000000 00000000
I 00 00000000 80D51234 15 00 06 0 0 0 11110015 00000000 00000000 00000000
I 00 00000000 906500FF 00 00 03 5 0 0 00000000 00000000 22220005 00000000
I 00 00000000 9656ABCD 00 00 12 6 0 0 00000000 00000000 22220006 00000000
I 00 00000000 98E30000 03 00 07 0 0 0 11110003 00000000 00000000 00000000
I 00 00000000 9CA60010 06 00 00 5 0 5 11110006 00000000 22220005 00000000
I 00 00000000 A2B28000 12 00 15 0 0 0 11110012 00000000 00000000 00000000
I 00 00000000 B1230004 03 00 09 0 0 0 11110003 00000000 00000000 00000000
I 00 00000000 B8C50008 05 00 00 0 0 6 11110005 00000000 00000000 00000000
I 00 00000000 C0A30040 00 00 00 0 0 0 00000000 00000000 00000000 00000000
I 00 00000000 F2B20020 12 15 00 0 0 0 11110012 11110015 00000000 00000000
I 00 00000000 FC660000 06 00 00 3 0 0 11110006 00000000 22220003 00000000
I 00 00000000 00700000 00 00 00 0 0 3 00000000 00000000 00000000 00000000
I 00 00000000 30201800 00 03 01 0 0 0 00000000 11110003 00000000 00000000
B 05 55550005 20452800 00 05 00 5 0 2 00000000 55550005 55550005 00000000
B 12 66660012 30321800 12 03 01 0 0 0 66660012 11110003 00000000 00000000
I 00 00000000 40259000 05 12 01 0 0 0 55550005 66660012 00000000 00000000
B 00 77777777 3080A800 00 15 04 0 0 0 00000000 11110015 00000000 00000000

// ==== list.f ====
vec_proc_pkg.sv
address_decode_unit.sv
scalar_reg_file.sv
vector_reg_file.sv
decode_stage.sv
decode_stage_props.sv
tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_decode_stage -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_decode_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

// ==== scalar_reg_file.sv ====
module scalar_reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  vec_proc_pkg::sreg_addr_t rd_addr_a,
    input  vec_proc_pkg::sreg_addr_t rd_addr_b,
    output logic [31:0]              rd_data_a,
    output logic [31:0]              rd_data_b,
    input  logic                     wr_en,
    input  vec_proc_pkg::sreg_addr_t wr_addr,
    input  logic [31:0]              wr_data
);
    import vec_proc_pkg::*;

    logic [31:0] regs [SREG_COUNT];
    logic        wr_live;
    logic        hit_a;
    logic        hit_b;

    // Writes to r0 never land
    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign hit_a = wr_live && (wr_addr == rd_addr_a);
    assign hit_b = wr_live && (wr_addr == rd_addr_b);

    // Same-cycle write bypass
    always_comb begin
        rd_data_a = regs[rd_addr_a];
        rd_data_b = regs[rd_addr_b];
        if (hit_a) begin
            rd_data_a = wr_data;
        end
        if (hit_b) begin
            rd_data_b = wr_data;
        end
        if (rd_addr_a == '0) begin
            rd_data_a = '0;
        end
        if (rd_addr_b == '0) begin
            rd_data_b = '0;
        end
    end

endmodule

// ==== tb_decode_stage.sv ====
module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import vec_proc_pkg::*;

    localparam int LANES = 4;
    localparam int VW    = LANES * 32;

    typedef logic [VW-1:0] wide_t;

    // One line of the stimulus file
    typedef struct packed {
        logic [7:0]  op;
        sreg_addr_t  wr_addr;
        logic [31:0] wr_data;
        instr_t      instr;
        reg_addrs_t  addrs;
        logic [31:0] s1_data;
        logic [31:0] s2_data;
        logic [31:0] v1_lane;
        logic [31:0] v2_lane;
    } step_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    instr_t      instr;
    logic        s_wr_en;
    sreg_addr_t  s_wr_addr;
    logic [31:0] s_wr_data;
    logic        v_wr_en;
    vreg_addr_t  v_wr_addr;
    wide_t       v_wr_data;
    de_scalar_t  de_out;
    wide_t       de_v1_data;
    wide_t       de_v2_data;

    step_t steps[$];
    int    mismatches;
    int    tests;
    int    failed;
    bit    loaded;

    decode_stage #(
        .LANES (LANES)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .s_wr_en     (s_wr_en),
        .s_wr_addr   (s_wr_addr),
        .s_wr_data   (s_wr_data),
        .v_wr_en     (v_wr_en),
        .v_wr_addr   (v_wr_addr),
        .v_wr_data   (v_wr_data),
        .de_out      (de_out),
        .de_v1_data  (de_v1_data),
        .de_v2_data  (de_v2_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Budget is one cycle per step plus reset and some slack
    initial begin
        wait (loaded);
        #((steps.size() + 16 + 20) * 10);
        $display("Timeout: the decode stage run did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    task automatic compare(string name, wide_t expected, wide_t actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          got;
        string       line;
        logic [7:0]  op;
        logic [31:0] f [13];
        step_t       s;

        fd = $fopen("decode_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file decode_stim.txt");
            failed++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h", op,
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                              f[7], f[8], f[9], f[10], f[11], f[12]);
                if (got != 14) begin
                    $display("Malformed stimulus line: %s", line);
                    failed++;
                end else begin
                    s.op        = op;
                    s.wr_addr   = f[0][4:0];
                    s.wr_data   = f[1];
                    s.instr     = f[2];
                    s.addrs.s1  = f[3][4:0];
                    s.addrs.s2  = f[4][4:0];
                    s.addrs.swb = f[5][4:0];
                    s.addrs.v1  = f[6][3:0];
                    s.addrs.v2  = f[7][3:0];
                    s.addrs.vwb = f[8][3:0];
                    s.s1_data   = f[9];
                    s.s2_data   = f[10];
                    s.v1_lane   = f[11];
                    s.v2_lane   = f[12];
                    steps.push_back(s);
                end
            end
        end
        $fclose(fd);
    endtask

    // B drives the scalar and the vector write port with the same address and data
    task automatic drive_step(step_t s);
        instr_valid = (s.op == "I" || s.op == "B");
        instr       = s.instr;
        s_wr_en     = (s.op == "W" || s.op == "B");
        s_wr_addr   = s.wr_addr;
        s_wr_data   = s.wr_data;
        v_wr_en     = (s.op == "V" || s.op == "B");
        v_wr_addr   = s.wr_addr[3:0];
        v_wr_data   = {LANES{s.wr_data}};
    endtask

    task automatic report(string name);
        tests++;
        if (mismatches == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, mismatches);
            failed++;
        end
    endtask

    task automatic check_outputs(step_t s, int idx);
        mismatches = 0;
        compare("de_out.valid", wide_t'(1'b1), wide_t'(de_out.valid));
        compare("de_out.instr", wide_t'(s.instr), wide_t'(de_out.instr));
        compare("de_out.addrs.s1", wide_t'(s.addrs.s1), wide_t'(de_out.addrs.s1));
        compare("de_out.addrs.s2", wide_t'(s.addrs.s2), wide_t'(de_out.addrs.s2));
        compare("de_out.addrs.swb", wide_t'(s.addrs.swb), wide_t'(de_out.addrs.swb));
        compare("de_out.addrs.v1", wide_t'(s.addrs.v1), wide_t'(de_out.addrs.v1));
        compare("de_out.addrs.v2", wide_t'(s.addrs.v2), wide_t'(de_out.addrs.v2));
        compare("de_out.addrs.vwb", wide_t'(s.addrs.vwb), wide_t'(de_out.addrs.vwb));
        compare("de_out.s1_data", wide_t'(s.s1_data), wide_t'(de_out.s1_data));
        compare("de_out.s2_data", wide_t'(s.s2_data), wide_t'(de_out.s2_data));
        compare("de_v1_data", {LANES{s.v1_lane}}, de_v1_data);
        compare("de_v2_data", {LANES{s.v2_lane}}, de_v2_data);
        report($sformatf("step %0d (%c)", idx, s.op));
    endtask

    initial begin
        rst_n = 1'b0;
        drive_step('0);
        load_stimulus();
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        mismatches = 0;
        compare("de_out", '0, wide_t'(de_out));
        compare("de_v1_data", '0, de_v1_data);
        compare("de_v2_data", '0, de_v2_data);
        report("reset");

        // Each step is checked on the falling edge after the one that drove it
        for (int i = 0; i < steps.size(); i++) begin
            drive_step(steps[i]);
            @(negedge clk);
            if (steps[i].op == "I" || steps[i].op == "B") begin
                check_outputs(steps[i], i + 1);
            end
        end
        drive_step('0);

        $display("tests %0d, passed %0d, failed %0d", tests, tests - failed, failed);
        if (failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== vec_proc_pkg.sv ====
package vec_proc_pkg;

    parameter int SREG_COUNT = 32;
    parameter int VREG_COUNT = 16;

    typedef logic [4:0] sreg_addr_t;
    typedef logic [3:0] vreg_addr_t;

    // Register form, bit 31 clear
    typedef struct packed {
        logic        mode;
        logic [2:0]  cls;
        logic [1:0]  spare;
        logic [4:0]  dst;
        logic [4:0]  src1;
        logic [4:0]  src2;
        logic [10:0] func;
    } reg_form_t;

    // Immediate form, bit 31 set
    typedef struct packed {
        logic        mode;
        logic        wr_dis;
        logic [1:0]  cls;
        logic [1:0]  sub;
        logic [4:0]  dst;
        logic [4:0]  src;
        logic [15:0] imm;
    } imm_form_t;

    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } instr_t;

    typedef struct packed {
        sreg_addr_t s1;
        sreg_addr_t s2;
        sreg_addr_t swb;
        vreg_addr_t v1;
        vreg_addr_t v2;
        vreg_addr_t vwb;
    } reg_addrs_t;

    typedef struct packed {
        logic        valid;
        instr_t      instr;
        reg_addrs_t  addrs;
        logic [31:0] s1_data;
        logic [31:0] s2_data;
    } de_scalar_t;

endpackage

// ==== vector_reg_file.sv ====
module vector_reg_file #(
    parameter int LANES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  vec_proc_pkg::vreg_addr_t rd_addr_a,
    input  vec_proc_pkg::vreg_addr_t rd_addr_b,
    output logic [LANES*32-1:0]      rd_data_a,
    output logic [LANES*32-1:0]      rd_data_b,
    input  logic                     wr_en,
    input  vec_proc_pkg::vreg_addr_t wr_addr,
    input  logic [LANES*32-1:0]      wr_data
);
    import vec_proc_pkg::*;

    localparam int VW = LANES * 32;

    logic [VW-1:0] regs [VREG_COUNT];
    logic          wr_live;
    logic          hit_a;
    logic          hit_b;

    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < VREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign hit_a = wr_live && (wr_addr == rd_addr_a);
    assign hit_b = wr_live && (wr_addr == rd_addr_b);

    // v0 reads zero, otherwise a pending write wins over the stored entry
    always_comb begin
        if (rd_addr_a == '0) begin
            rd_data_a = '0;
        end else if (hit_a) begin
            rd_data_a = wr_data;
        end else begin
            rd_data_a = regs[rd_addr_a];
        end

        if (rd_addr_b == '0) begin
            rd_data_b = '0;
        end else if (hit_b) begin
            rd_data_b = wr_data;
        end else begin
            rd_data_b = regs[rd_addr_b];
        end
    end

endmodule
